// File: compile.f
+incdir+verif
src/manycore_pkg.sv
src/wh_pkg.sv
src/wb_host_port.sv
src/vcache_tile.sv
src/vcache_tile_array.sv
src/edge_mem_ctrl.sv
src/vcache_subsystem.sv
verif/tb_vcache_subsystem.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vcache_subsystem
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_util.svh
// ====================================================================
// testbench helpers
// galois lfsr for stimulus, value compare and bounded ack wait
// ====================================================================
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

localparam int ack_timeout_c = 200;

// right-shifting form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] next;
  next = state >> 1;
  if (state[0]) begin
    next = next ^ 32'h80200003;
  end
  return next;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] take_bits(input int count);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < count; i++) begin
    value = {value[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return value;
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (aborted) return;
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("Fail: %s is %h, expected %h", name, actual, expected);
  end
endtask

// ack is looked at just after each rising edge
task automatic wait_for_ack(output logic seen, output int cycles);
  seen = 1'b0;
  cycles = 0;
  while (!seen && cycles < ack_timeout_c) begin
    @(posedge clk);
    #1;
    cycles++;
    seen = wb_ack;
  end
endtask

`endif

// File: verif/tb_vcache_subsystem.sv
// ====================================================================
// vcache subsystem testbench
// random wishbone traffic checked against a flat word model
// ====================================================================
module tb_vcache_subsystem;

  localparam int num_tiles_c = 4;
  localparam int sets_c = 16;
  localparam int mem_words_c = 1024;
  localparam int model_words_c = mem_words_c * num_tiles_c;
  localparam int model_bits_c = $clog2(model_words_c);
  localparam int pool_bits_c = 5;
  localparam int pool_size_c = 1 << pool_bits_c;
  // flips the lowest tag bit and keeps tile and set
  localparam logic [15:0] partner_c = 16'h0040;
  // read hit: register the request, look up the line, ack
  localparam int hit_latency_c = 3;

  logic clk;
  logic reset;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [15:0] wb_adr;
  logic [3:0] wb_sel;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic wb_ack;

  logic [31:0] lfsr_state;
  int checks;
  int errors;
  int ack_cycles;
  logic aborted;
  logic [31:0] model_mem [model_words_c];
  // pairs of conflicting addresses written in the first test
  logic [15:0] pool [pool_size_c];

  `include "tb_util.svh"

  vcache_subsystem #(
    .num_tiles_p(num_tiles_c)
    ,.sets_p(sets_c)
    ,.mem_words_p(mem_words_c)
  ) UUT (
    .clk_i(clk)
    ,.reset_i(reset)
    ,.wb_cyc_i(wb_cyc)
    ,.wb_stb_i(wb_stb)
    ,.wb_we_i(wb_we)
    ,.wb_adr_i(wb_adr)
    ,.wb_sel_i(wb_sel)
    ,.wb_dat_i(wb_dat_w)
    ,.wb_dat_o(wb_dat_r)
    ,.wb_ack_o(wb_ack)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] apply_sel(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // one wishbone classic cycle, entered just after a rising edge
  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [3:0] sel,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic seen;
    rdata = '0;
    if (aborted) return;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_sel = sel;
    wb_dat_w = wdata;
    wait_for_ack(seen, ack_cycles);
    if (!seen) begin
      $display("no ack from the DUT within %0d cycles for address %h", ack_timeout_c, adr);
      errors++;
      aborted = 1'b1;
    end else begin
      rdata = wb_dat_r;
      if (we) begin
        model_mem[adr[model_bits_c-1:0]] = apply_sel(model_mem[adr[model_bits_c-1:0]],
                                                     wdata, sel);
      end
    end
    // cyc stays up through the ack cycle
    @(posedge clk);
    #1;
    // ack is a single-cycle pulse
    if (seen) begin
      check_value("wb_ack_o", wb_ack, 1'b0);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic write_word(input logic [15:0] adr, input logic [3:0] sel,
                            input logic [31:0] data);
    logic [31:0] ignored;
    bus_access(1'b1, adr, sel, data, ignored);
  endtask

  task automatic read_check(input logic [15:0] adr);
    logic [31:0] rd;
    bus_access(1'b0, adr, 4'h0, 32'h0, rd);
    check_value($sformatf("wb_dat_o at %h", adr), rd, model_mem[adr[model_bits_c-1:0]]);
  endtask

  task automatic report_test(input string name, input int checks_before,
                             input int errors_before);
    $display("%s: %0d checks, %0d errors", name, checks - checks_before,
             errors - errors_before);
  endtask

  initial begin
    int c0;
    int e0;
    logic [15:0] a;
    logic [15:0] b;
    logic [3:0] pair;
    logic hit_first;
    clk = 1'b0;
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_sel = '0;
    wb_dat_w = '0;
    lfsr_state = 32'h197e19f7;
    checks = 0;
    errors = 0;
    ack_cycles = 0;
    aborted = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < pool_size_c; i += 2) begin
      pool[i] = 16'(take_bits(model_bits_c));
      pool[i+1] = pool[i] ^ partner_c;
    end
    for (int i = 0; i < pool_size_c; i++) write_word(pool[i], 4'hf, take_bits(32));
    for (int i = 0; i < pool_size_c; i++) read_check(pool[i]);
    report_test("init and read back", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      a = pool[pool_bits_c'(take_bits(pool_bits_c))];
      read_check(a);
      // the second read finds the line filled
      read_check(a);
      check_value("wb_ack_o latency", ack_cycles, hit_latency_c);
    end
    report_test("repeated reads", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 24; i++) begin
      a = pool[pool_bits_c'(take_bits(pool_bits_c))];
      hit_first = take_bits(1) != 0;
      // reading the partner evicts the line
      read_check(hit_first ? a : a ^ partner_c);
      write_word(a, 4'(take_bits(4)), take_bits(32));
      read_check(a);
    end
    report_test("byte-masked writes", c0, e0);

    c0 = checks;
    e0 = errors;
    pair = 4'(take_bits(4));
    a = pool[{pair, 1'b0}];
    b = pool[{pair, 1'b1}];
    for (int i = 0; i < 12; i++) begin
      write_word((take_bits(1) != 0) ? a : b, 4'(take_bits(4)), take_bits(32));
      read_check(a);
      read_check(b);
    end
    report_test("conflicting addresses", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      a = pool[pool_bits_c'(take_bits(pool_bits_c))];
      if (take_bits(1) != 0) begin
        write_word(a, 4'(take_bits(4)), take_bits(32));
      end else begin
        read_check(a);
      end
    end
    report_test("random mix", c0, e0);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: src/vcache_subsystem.sv
// ====================================================================
// vcache subsystem
// wishbone host port, a row of vcache tiles and the edge memory
// ====================================================================
module vcache_subsystem
  #(parameter int num_tiles_p = 4
    , parameter int sets_p = 16
    , parameter int mem_words_p = 1024
  )
  ( input  logic clk_i
  , input  logic reset_i
  , input  logic wb_cyc_i
  , input  logic wb_stb_i
  , input  logic wb_we_i
  , input  logic [manycore_pkg::addr_width_c-1:0] wb_adr_i
  , input  logic [manycore_pkg::sel_width_c-1:0] wb_sel_i
  , input  logic [manycore_pkg::data_width_c-1:0] wb_dat_i
  , output logic [manycore_pkg::data_width_c-1:0] wb_dat_o
  , output logic wb_ack_o
  );

  import manycore_pkg::*;
  import wh_pkg::*;

  localparam int tile_bits_lp = tile_bits_f(num_tiles_p);
  localparam int local_addr_width_lp = local_addr_width_f(num_tiles_p);

  // host port to tiles
  logic req_v;
  logic [tile_bits_lp-1:0] req_tile;
  logic [local_addr_width_lp-1:0] req_addr;
  logic req_we;
  logic [sel_width_c-1:0] req_sel;
  logic [data_width_c-1:0] req_data;
  logic resp_v;
  logic [data_width_c-1:0] resp_data;

  // tiles to edge memory
  wh_flit_u flit;
  logic flit_v;
  logic flit_ready;
  logic mem_resp_v;
  logic [data_width_c-1:0] mem_resp_data;
  logic [max_tile_bits_c-1:0] mem_resp_tile;

  wb_host_port #(
    .num_tiles_p(num_tiles_p)
  ) host (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.wb_cyc_i(wb_cyc_i)
    ,.wb_stb_i(wb_stb_i)
    ,.wb_we_i(wb_we_i)
    ,.wb_adr_i(wb_adr_i)
    ,.wb_sel_i(wb_sel_i)
    ,.wb_dat_i(wb_dat_i)
    ,.wb_dat_o(wb_dat_o)
    ,.wb_ack_o(wb_ack_o)
    ,.req_v_o(req_v)
    ,.req_tile_o(req_tile)
    ,.req_addr_o(req_addr)
    ,.req_we_o(req_we)
    ,.req_sel_o(req_sel)
    ,.req_data_o(req_data)
    ,.resp_v_i(resp_v)
    ,.resp_data_i(resp_data)
  );

  vcache_tile_array #(
    .num_tiles_p(num_tiles_p)
    ,.sets_p(sets_p)
  ) tiles (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.req_v_i(req_v)
    ,.req_tile_i(req_tile)
    ,.req_addr_i(req_addr)
    ,.req_we_i(req_we)
    ,.req_sel_i(req_sel)
    ,.req_data_i(req_data)
    ,.resp_v_o(resp_v)
    ,.resp_data_o(resp_data)
    ,.flit_o(flit)
    ,.flit_v_o(flit_v)
    ,.flit_ready_i(flit_ready)
    ,.mem_resp_v_i(mem_resp_v)
    ,.mem_resp_data_i(mem_resp_data)
    ,.mem_resp_tile_i(mem_resp_tile)
  );

  edge_mem_ctrl #(
    .num_tiles_p(num_tiles_p)
    ,.mem_words_p(mem_words_p)
  ) edge_mem (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.flit_i(flit)
    ,.flit_v_i(flit_v)
    ,.flit_ready_o(flit_ready)
    ,.mem_resp_v_o(mem_resp_v)
    ,.mem_resp_data_o(mem_resp_data)
    ,.mem_resp_tile_o(mem_resp_tile)
  );

endmodule

// File: src/edge_mem_ctrl.sv
// ====================================================================
// edge memory controller
// takes header and data flits off the link, does the ram read or the
// byte-masked write and answers the source tile once per packet
// ====================================================================
module edge_mem_ctrl
  #(parameter int num_tiles_p = 4
    , parameter int mem_words_p = 1024
    , localparam int tile_bits_lp = manycore_pkg::tile_bits_f(num_tiles_p)
    , localparam int word_bits_lp = $clog2(mem_words_p)
    , localparam int ram_words_lp = mem_words_p * num_tiles_p
  )
  ( input  logic clk_i
  , input  logic reset_i
  , input  wh_pkg::wh_flit_u flit_i
  , input  logic flit_v_i
  , output logic flit_ready_o
  , output logic mem_resp_v_o
  , output logic [manycore_pkg::data_width_c-1:0] mem_resp_data_o
  , output logic [manycore_pkg::max_tile_bits_c-1:0] mem_resp_tile_o
  );

  import manycore_pkg::*;
  import wh_pkg::*;

  // mem_words_p words behind each tile
  logic [data_width_c-1:0] ram [ram_words_lp];

  logic    expect_data_r;
  wh_hdr_s hdr_r;
  logic accept;
  logic take_hdr;
  logic take_data;
  logic [word_bits_lp+tile_bits_lp-1:0] hdr_idx;
  logic [word_bits_lp+tile_bits_lp-1:0] pend_idx;

  // rebuild the interleaved host address
  function automatic logic [word_bits_lp+tile_bits_lp-1:0] ram_idx_f(input wh_hdr_s hdr);
    return {hdr.addr[word_bits_lp-1:0], hdr.src_tile[tile_bits_lp-1:0]};
  endfunction

  assign flit_ready_o = !mem_resp_v_o;
  assign accept    = flit_v_i && flit_ready_o;
  assign take_hdr  = accept && !expect_data_r;
  assign take_data = accept && expect_data_r;
  assign hdr_idx   = ram_idx_f(flit_i.hdr);
  assign pend_idx  = ram_idx_f(hdr_r);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      expect_data_r <= 1'b0;
      mem_resp_v_o  <= 1'b0;
    end else begin
      mem_resp_v_o <= take_data || (take_hdr && !flit_i.hdr.has_data);
      if (take_hdr) begin
        expect_data_r <= flit_i.hdr.has_data;
      end else if (take_data) begin
        expect_data_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_hdr) begin
      hdr_r <= flit_i.hdr;
      mem_resp_tile_o <= flit_i.hdr.src_tile;
      mem_resp_data_o <= (flit_i.hdr.opcode == wh_op_read_e) ? ram[hdr_idx] : '0;
    end
    if (take_data) begin
      ram[pend_idx] <= merge_bytes_f(ram[pend_idx], flit_i.payload.data, hdr_r.sel);
      // write completion carries no data
      mem_resp_data_o <= '0;
    end
  end

endmodule

// File: src/vcache_tile_array.sv
// ====================================================================
// vcache tile array
// row of tiles sharing one flit link; steers host requests to the
// addressed tile and memory responses to the tile that asked
// ====================================================================
module vcache_tile_array
  #(parameter int num_tiles_p = 4
    , parameter int sets_p = 16
    , localparam int tile_bits_lp = manycore_pkg::tile_bits_f(num_tiles_p)
    , localparam int local_addr_width_lp = manycore_pkg::local_addr_width_f(num_tiles_p)
  )
  ( input  logic clk_i
  , input  logic reset_i
  , input  logic req_v_i
  , input  logic [tile_bits_lp-1:0] req_tile_i
  , input  logic [local_addr_width_lp-1:0] req_addr_i
  , input  logic req_we_i
  , input  logic [manycore_pkg::sel_width_c-1:0] req_sel_i
  , input  logic [manycore_pkg::data_width_c-1:0] req_data_i
  , output logic resp_v_o
  , output logic [manycore_pkg::data_width_c-1:0] resp_data_o
  , output wh_pkg::wh_flit_u flit_o
  , output logic flit_v_o
  , input  logic flit_ready_i
  , input  logic mem_resp_v_i
  , input  logic [manycore_pkg::data_width_c-1:0] mem_resp_data_i
  , input  logic [manycore_pkg::max_tile_bits_c-1:0] mem_resp_tile_i
  );

  import manycore_pkg::*;
  import wh_pkg::*;

  logic [num_tiles_p-1:0]  tile_req_v;
  logic [num_tiles_p-1:0]  tile_resp_v;
  logic [num_tiles_p-1:0]  tile_flit_v;
  logic [num_tiles_p-1:0]  tile_mem_resp_v;
  logic [data_width_c-1:0] tile_resp_data [num_tiles_p];
  wh_flit_u                tile_flit [num_tiles_p];

  for (genvar i = 0; i < num_tiles_p; i++) begin : tile
    assign tile_req_v[i] = req_v_i && (req_tile_i == tile_bits_lp'(i));
    assign tile_mem_resp_v[i] = mem_resp_v_i && (mem_resp_tile_i == max_tile_bits_c'(i));

    vcache_tile #(
      .num_tiles_p(num_tiles_p)
      ,.sets_p(sets_p)
    ) vc (
      .clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.req_v_i(tile_req_v[i])
      ,.req_addr_i(req_addr_i)
      ,.req_we_i(req_we_i)
      ,.req_sel_i(req_sel_i)
      ,.req_data_i(req_data_i)
      ,.resp_v_o(tile_resp_v[i])
      ,.resp_data_o(tile_resp_data[i])
      ,.flit_o(tile_flit[i])
      ,.flit_v_o(tile_flit_v[i])
      ,.flit_ready_i(flit_ready_i)
      ,.mem_resp_v_i(tile_mem_resp_v[i])
      ,.mem_resp_data_i(mem_resp_data_i)
      ,.tile_id_i(max_tile_bits_c'(i))
    );
  end

  // only the busy tile ever drives, so an OR and a pick are enough
  always_comb begin
    resp_data_o = '0;
    flit_o = '0;
    for (int i = 0; i < num_tiles_p; i++) begin
      if (tile_resp_v[i]) resp_data_o = resp_data_o | tile_resp_data[i];
      if (tile_flit_v[i]) flit_o = tile_flit[i];
    end
  end

  assign resp_v_o = |tile_resp_v;
  assign flit_v_o = |tile_flit_v;

  one_sender: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(tile_flit_v));

endmodule

// File: src/vcache_tile.sv
// ====================================================================
// vcache tile
// direct-mapped, write-through, no-write-allocate cache of one-word
// lines; misses and writes go to edge memory as flit packets
// ====================================================================
module vcache_tile
  #(parameter int num_tiles_p = 4
    , parameter int sets_p = 16
    , localparam int local_addr_width_lp = manycore_pkg::local_addr_width_f(num_tiles_p)
    , localparam int set_bits_lp = $clog2(sets_p)
    , localparam int tag_width_lp = local_addr_width_lp - set_bits_lp
  )
  ( input  logic clk_i
  , input  logic reset_i
  , input  logic req_v_i
  , input  logic [local_addr_width_lp-1:0] req_addr_i
  , input  logic req_we_i
  , input  logic [manycore_pkg::sel_width_c-1:0] req_sel_i
  , input  logic [manycore_pkg::data_width_c-1:0] req_data_i
  , output logic resp_v_o
  , output logic [manycore_pkg::data_width_c-1:0] resp_data_o
  , output wh_pkg::wh_flit_u flit_o
  , output logic flit_v_o
  , input  logic flit_ready_i
  , input  logic mem_resp_v_i
  , input  logic [manycore_pkg::data_width_c-1:0] mem_resp_data_i
  , input  logic [manycore_pkg::max_tile_bits_c-1:0] tile_id_i
  );

  import manycore_pkg::*;
  import wh_pkg::*;

  typedef enum logic [1:0] {idle_s, send_hdr_s, send_data_s, wait_s} state_e;

  state_e state_r;

  logic [sets_p-1:0]       valid_r;
  logic [tag_width_lp-1:0] tag_mem [sets_p];
  logic [data_width_c-1:0] data_mem [sets_p];

  // request held while memory is involved
  logic [local_addr_width_lp-1:0] addr_r;
  logic                    we_r;
  logic [sel_width_c-1:0]  sel_r;
  logic [data_width_c-1:0] data_r;

  logic [set_bits_lp-1:0]  req_idx;
  logic [set_bits_lp-1:0]  pend_idx;
  logic [tag_width_lp-1:0] req_tag;
  logic [tag_width_lp-1:0] pend_tag;
  logic req_hit;
  logic pend_hit;
  logic read_hit;
  logic mem_done;

  assign req_idx  = req_addr_i[set_bits_lp-1:0];
  assign req_tag  = req_addr_i[local_addr_width_lp-1:set_bits_lp];
  assign req_hit  = valid_r[req_idx] && (tag_mem[req_idx] == req_tag);
  assign pend_idx = addr_r[set_bits_lp-1:0];
  assign pend_tag = addr_r[local_addr_width_lp-1:set_bits_lp];
  assign pend_hit = valid_r[pend_idx] && (tag_mem[pend_idx] == pend_tag);

  assign read_hit = (state_r == idle_s) && req_v_i && !req_we_i && req_hit;
  assign mem_done = (state_r == wait_s) && mem_resp_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= idle_s;
      resp_v_o <= 1'b0;
      valid_r  <= '0;
    end else begin
      resp_v_o <= read_hit || mem_done;
      case (state_r)
        idle_s: if (req_v_i && !read_hit) state_r <= send_hdr_s;
        send_hdr_s: if (flit_ready_i) state_r <= we_r ? send_data_s : wait_s;
        send_data_s: if (flit_ready_i) state_r <= wait_s;
        default: begin
          if (mem_resp_v_i) begin
            state_r <= idle_s;
            // only a read miss allocates
            if (!we_r) valid_r[pend_idx] <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == idle_s) && req_v_i) begin
      addr_r <= req_addr_i;
      we_r   <= req_we_i;
      sel_r  <= req_sel_i;
      data_r <= req_data_i;
    end
    if (read_hit) begin
      resp_data_o <= data_mem[req_idx];
    end
    if (mem_done) begin
      resp_data_o <= mem_resp_data_i;
      if (!we_r) begin
        tag_mem[pend_idx]  <= pend_tag;
        data_mem[pend_idx] <= mem_resp_data_i;
      end else if (pend_hit) begin
        data_mem[pend_idx] <= merge_bytes_f(data_mem[pend_idx], data_r, sel_r);
      end
    end
  end

  // header first, then the write data
  always_comb begin
    flit_o = '0;
    if (state_r == send_data_s) begin
      flit_o.payload.data = data_r;
    end else begin
      flit_o.hdr.opcode   = we_r ? wh_op_write_e : wh_op_read_e;
      flit_o.hdr.sel      = sel_r;
      flit_o.hdr.has_data = we_r;
      flit_o.hdr.src_tile = tile_id_i;
      flit_o.hdr.addr     = addr_width_c'(addr_r);
    end
  end

  assign flit_v_o = (state_r == send_hdr_s) || (state_r == send_data_s);

  flit_held: assert property (@(posedge clk_i) disable iff (reset_i)
    flit_v_o && !flit_ready_i |=> flit_v_o && $stable(flit_o));

endmodule

// File: src/wb_host_port.sv
// ====================================================================
// wishbone host port
// classic slave that takes one word request, splits the address into
// tile index and local address and waits for the tile to answer
// ====================================================================
module wb_host_port
  #(parameter int num_tiles_p = 4
    , localparam int tile_bits_lp = manycore_pkg::tile_bits_f(num_tiles_p)
    , localparam int local_addr_width_lp = manycore_pkg::local_addr_width_f(num_tiles_p)
  )
  ( input  logic clk_i
  , input  logic reset_i
  , input  logic wb_cyc_i
  , input  logic wb_stb_i
  , input  logic wb_we_i
  , input  logic [manycore_pkg::addr_width_c-1:0] wb_adr_i
  , input  logic [manycore_pkg::sel_width_c-1:0] wb_sel_i
  , input  logic [manycore_pkg::data_width_c-1:0] wb_dat_i
  , output logic [manycore_pkg::data_width_c-1:0] wb_dat_o
  , output logic wb_ack_o
  , output logic req_v_o
  , output logic [tile_bits_lp-1:0] req_tile_o
  , output logic [local_addr_width_lp-1:0] req_addr_o
  , output logic req_we_o
  , output logic [manycore_pkg::sel_width_c-1:0] req_sel_o
  , output logic [manycore_pkg::data_width_c-1:0] req_data_o
  , input  logic resp_v_i
  , input  logic [manycore_pkg::data_width_c-1:0] resp_data_i
  );

  import manycore_pkg::*;

  typedef enum logic [1:0] {idle_s, busy_s, ack_s} state_e;

  state_e state_r;
  logic start;

  assign start = (state_r == idle_s) && wb_cyc_i && wb_stb_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= idle_s;
      req_v_o <= 1'b0;
    end else begin
      req_v_o <= start;
      case (state_r)
        idle_s: if (start) state_r <= busy_s;
        busy_s: if (resp_v_i) state_r <= ack_s;
        // ack lasts one cycle, the host drops stb after it
        default: state_r <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      req_tile_o <= wb_adr_i[tile_bits_lp-1:0];
      req_addr_o <= wb_adr_i[addr_width_c-1:tile_bits_lp];
      req_we_o   <= wb_we_i;
      req_sel_o  <= wb_sel_i;
      req_data_o <= wb_dat_i;
    end
    if ((state_r == busy_s) && resp_v_i) begin
      wb_dat_o <= resp_data_i;
    end
  end

  assign wb_ack_o = (state_r == ack_s);

  ack_inside_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_o |-> wb_cyc_i);

endmodule

// File: src/wh_pkg.sv
// ====================================================================
// wormhole flit definitions
// opcodes and the flit word of the tile-to-edge link, which carries
// either a packet header or a data word
// ====================================================================
package wh_pkg;

  localparam int flit_width_c = 40;

  typedef enum logic [1:0] {
    wh_op_read_e  = 2'b00,
    wh_op_write_e = 2'b01
  } wh_op_e;

  // bits taken by the header fields
  localparam int hdr_used_c = 2 + manycore_pkg::sel_width_c + 1
                              + manycore_pkg::max_tile_bits_c + manycore_pkg::addr_width_c;

  typedef struct packed {
    wh_op_e                                opcode;
    logic [manycore_pkg::sel_width_c-1:0]  sel;
    // a data flit follows this header
    logic                                  has_data;
    logic [manycore_pkg::max_tile_bits_c-1:0] src_tile;
    logic [manycore_pkg::addr_width_c-1:0] addr;
    logic [flit_width_c-hdr_used_c-1:0]    unused;
  } wh_hdr_s;

  typedef struct packed {
    logic [manycore_pkg::data_width_c-1:0]            data;
    logic [flit_width_c-manycore_pkg::data_width_c-1:0] unused;
  } wh_data_s;

  // same 40 bits, decoded by position in the packet
  typedef union packed {
    wh_hdr_s  hdr;
    wh_data_s payload;
  } wh_flit_u;

endpackage

// File: src/manycore_pkg.sv
// ====================================================================
// manycore word and address definitions
// data, address and byte-select widths seen by the host, plus helpers
// that split a host address into tile index and local address
// ====================================================================
package manycore_pkg;

  localparam int data_width_c = 32;
  localparam int addr_width_c = 16;
  localparam int sel_width_c = data_width_c / 8;
  // room for a tile index inside a packet header
  localparam int max_tile_bits_c = 4;

  // tile index sits in the low address bits
  function automatic int tile_bits_f(input int num_tiles);
    return (num_tiles > 1) ? $clog2(num_tiles) : 1;
  endfunction

  function automatic int local_addr_width_f(input int num_tiles);
    return addr_width_c - tile_bits_f(num_tiles);
  endfunction

  // byte lanes with sel set come from new_word
  function automatic logic [data_width_c-1:0] merge_bytes_f(
    input logic [data_width_c-1:0] old_word,
    input logic [data_width_c-1:0] new_word,
    input logic [sel_width_c-1:0] sel
  );
    logic [data_width_c-1:0] merged;
    merged = old_word;
    for (int b = 0; b < sel_width_c; b++) begin
      if (sel[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage
